// File: mem_arbiter_top.f
rtl/snes_pkg.sv
rtl/mem_pkg.sv
rtl/snes_bus_sync.sv
rtl/rom_pipeline.sv
rtl/ram_pipeline.sv
rtl/mcu_response.sv
rtl/mem_arbiter_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mem_arbiter.sv

// File: rtl/mcu_response.sv
`timescale 1ns/1ps

module mcu_response (
  input  logic       CLK2,
  input  logic       arst_n,
  input  logic       rom_rdy,
  input  logic       ram_rdy,
  input  logic [7:0] rom_rdata,
  input  logic [7:0] ram_rdata,
  input  logic       rom_done,
  input  logic       ram_done,
  output logic       mcu_rdy,
  output logic [7:0] mcu_rdata
);

  // MCU sees a single memory, busy while either side works
  assign mcu_rdy = rom_rdy & ram_rdy;

  // latch the byte from whichever pipeline just ended a read
  always_ff @(posedge CLK2) begin
    if (rom_done) begin
      mcu_rdata <= rom_rdata;
    end else if (ram_done) begin
      mcu_rdata <= ram_rdata;
    end
  end

  // region decode sends each MCU read to exactly one pipeline
  a_done_exclusive: assert property (
    @(posedge CLK2) disable iff (!arst_n) !(rom_done && ram_done)
  );

endmodule

// File: rtl/mem_arbiter_top.sv
`timescale 1ns/1ps

module mem_arbiter_top
  import snes_pkg::*, mem_pkg::*;
#(
  parameter int DEAD_TIMEOUT = DEAD_TIMEOUT_DEFAULT
) (
  input  logic                  CLK2,
  input  logic                  arst_n,
  input  logic                  cpu_clk,
  input  logic                  is_rom,
  input  logic                  is_saveram,
  input  mcu_req_t              mcu,
  input  cop_rom_req_t          cop_rom,
  input  cop_ram_req_t          cop_ram,
  input  logic [ROM_DATA_W-1:0] rom_rdata,
  input  logic [RAM_DATA_W-1:0] ram_rdata,
  output rom_bus_t              rom,
  output ram_bus_t              ram,
  output logic                  mcu_rdy,
  output logic [7:0]            mcu_rdata,
  output logic                  cop_rom_rdy,
  output logic [ROM_DATA_W-1:0] cop_rom_rdata,
  output logic                  cop_ram_rdy,
  output logic [RAM_DATA_W-1:0] cop_ram_rdata
);

  snes_slot_t slot;
  logic       rom_mcu_rdy;
  logic       ram_mcu_rdy;
  logic [7:0] rom_mcu_rdata;
  logic [7:0] ram_mcu_rdata;
  logic       rom_mcu_done;
  logic       ram_mcu_done;

  snes_bus_sync #(
    .DEAD_TIMEOUT(DEAD_TIMEOUT)
  ) u_sync (
    .CLK2    (CLK2),
    .arst_n  (arst_n),
    .cpu_clk (cpu_clk),
    .slot    (slot)
  );

  // both pipelines see the MCU request, region decode picks one
  rom_pipeline u_rom (
    .CLK2      (CLK2),
    .arst_n    (arst_n),
    .slot      (slot),
    .is_rom    (is_rom),
    .mcu       (mcu),
    .cop       (cop_rom),
    .rom_rdata (rom_rdata),
    .rom       (rom),
    .mcu_rdy   (rom_mcu_rdy),
    .mcu_rdata (rom_mcu_rdata),
    .mcu_done  (rom_mcu_done),
    .cop_rdy   (cop_rom_rdy),
    .cop_rdata (cop_rom_rdata)
  );

  ram_pipeline u_ram (
    .CLK2       (CLK2),
    .arst_n     (arst_n),
    .slot       (slot),
    .is_saveram (is_saveram),
    .mcu        (mcu),
    .cop        (cop_ram),
    .ram_rdata  (ram_rdata),
    .ram        (ram),
    .mcu_rdy    (ram_mcu_rdy),
    .mcu_rdata  (ram_mcu_rdata),
    .mcu_done   (ram_mcu_done),
    .cop_rdy    (cop_ram_rdy),
    .cop_rdata  (cop_ram_rdata)
  );

  mcu_response u_resp (
    .CLK2      (CLK2),
    .arst_n    (arst_n),
    .rom_rdy   (rom_mcu_rdy),
    .ram_rdy   (ram_mcu_rdy),
    .rom_rdata (rom_mcu_rdata),
    .ram_rdata (ram_mcu_rdata),
    .rom_done  (rom_mcu_done),
    .ram_done  (ram_mcu_done),
    .mcu_rdy   (mcu_rdy),
    .mcu_rdata (mcu_rdata)
  );

endmodule

// File: rtl/mem_pkg.sv
package mem_pkg;

  // ----------------------------------------------------------------------
  // widths and access lengths
  // ----------------------------------------------------------------------

  localparam int ADDR_W     = 24;
  localparam int ROM_ADDR_W = 23;
  localparam int RAM_ADDR_W = 19;
  localparam int ROM_DATA_W = 16;
  localparam int RAM_DATA_W = 8;
  localparam int DELAY_W    = 4;

  // address phase runs for the cycle length plus one clock
  localparam logic [DELAY_W-1:0] ROM_CYCLE_LEN = 4'd7;
  localparam logic [DELAY_W-1:0] RAM_CYCLE_LEN = 4'd5;

  // top five MCU address bits that select the SRAM
  localparam logic [4:0] RAM_REGION = 5'b11100;

  // ----------------------------------------------------------------------
  // requests and memory buses
  // ----------------------------------------------------------------------

  // MCU address, either a ROM byte address or region plus SRAM offset
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    struct packed {
      logic [4:0]            region;
      logic [RAM_ADDR_W-1:0] ram_offset;
    } split;
  } mcu_addr_u;

  typedef struct packed {
    logic      rrq;
    logic      wrq;
    mcu_addr_u addr;
    logic [7:0] wdata;
  } mcu_req_t;

  typedef struct packed {
    logic              rrq;
    logic              word;
    logic [ADDR_W-1:0] addr;
  } cop_rom_req_t;

  typedef struct packed {
    logic                  rrq;
    logic                  wrq;
    logic [RAM_ADDR_W-1:0] addr;
    logic [RAM_DATA_W-1:0] wdata;
  } cop_ram_req_t;

  typedef struct packed {
    logic [ROM_ADDR_W-1:0] addr;
    logic [ROM_DATA_W-1:0] wdata;
    logic                  we_n;
    logic                  bhe_n;
    logic                  ble_n;
  } rom_bus_t;

  typedef struct packed {
    logic [RAM_ADDR_W-1:0] addr;
    logic [RAM_DATA_W-1:0] wdata;
    logic                  we_n;
  } ram_bus_t;

endpackage

// File: rtl/ram_pipeline.sv
`timescale 1ns/1ps

module ram_pipeline
  import snes_pkg::*, mem_pkg::*;
(
  input  logic                  CLK2,
  input  logic                  arst_n,
  input  snes_slot_t            slot,
  input  logic                  is_saveram,
  input  mcu_req_t              mcu,
  input  cop_ram_req_t          cop,
  input  logic [RAM_DATA_W-1:0] ram_rdata,
  output ram_bus_t              ram,
  output logic                  mcu_rdy,
  output logic [7:0]            mcu_rdata,
  output logic                  mcu_done,
  output logic                  cop_rdy,
  output logic [RAM_DATA_W-1:0] cop_rdata
);

  // END state is the bit above its ADDR state
  typedef enum logic [8:0] {
    S_IDLE        = 9'b000000001,
    S_COP_RD_ADDR = 9'b000000010,
    S_COP_RD_END  = 9'b000000100,
    S_COP_WR_ADDR = 9'b000001000,
    S_COP_WR_END  = 9'b000010000,
    S_MCU_RD_ADDR = 9'b000100000,
    S_MCU_RD_END  = 9'b001000000,
    S_MCU_WR_ADDR = 9'b010000000,
    S_MCU_WR_END  = 9'b100000000
  } state_t;

  state_t                state;
  logic [DELAY_W-1:0]    delay;
  logic                  mcu_hit;
  logic                  slot_free;
  logic                  mcu_rd_pend;
  logic                  mcu_wr_pend;
  logic                  cop_rd_pend;
  logic                  cop_wr_pend;
  logic [RAM_ADDR_W-1:0] mcu_addr_q;
  logic [7:0]            mcu_wdata_q;
  logic [RAM_ADDR_W-1:0] cop_addr_q;
  logic [RAM_DATA_W-1:0] cop_wdata_q;
  logic                  cop_hit;

  assign mcu_hit   = (mcu.addr.split.region == RAM_REGION);
  assign slot_free = slot.cycle_end | ~is_saveram | slot.dead;
  assign cop_hit   = (state == S_COP_RD_ADDR) || (state == S_COP_WR_ADDR);
  assign mcu_done  = (state == S_MCU_RD_END);

  // ----------------------------------------------------------------------
  // request capture
  // ----------------------------------------------------------------------

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end else if (mcu.rrq && mcu_hit) begin
      mcu_rd_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu.wrq && mcu_hit) begin
      mcu_wr_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (state == S_MCU_RD_END || state == S_MCU_WR_END) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      cop_rd_pend <= 1'b0;
      cop_wr_pend <= 1'b0;
      cop_rdy     <= 1'b1;
    end else if (cop.rrq) begin
      cop_rd_pend <= 1'b1;
      cop_rdy     <= 1'b0;
    end else if (cop.wrq) begin
      cop_wr_pend <= 1'b1;
      cop_rdy     <= 1'b0;
    end else if (state == S_COP_RD_END || state == S_COP_WR_END) begin
      cop_rd_pend <= 1'b0;
      cop_wr_pend <= 1'b0;
      cop_rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if ((mcu.rrq || mcu.wrq) && mcu_hit) begin
      mcu_addr_q  <= mcu.addr.split.ram_offset;
      mcu_wdata_q <= mcu.wdata;
    end
    if (cop.rrq || cop.wrq) begin
      cop_addr_q  <= cop.addr;
      cop_wdata_q <= cop.wdata;
    end
  end

  // ----------------------------------------------------------------------
  // arbitration FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_IDLE;
      delay <= '0;
    end else if (slot.revive) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          delay <= RAM_CYCLE_LEN;
          // coprocessor strobe may start the access in the same cycle
          if (slot_free) begin
            if (cop_rd_pend || cop.rrq) begin
              state <= S_COP_RD_ADDR;
            end else if (cop_wr_pend || cop.wrq) begin
              state <= S_COP_WR_ADDR;
            end else if (mcu_rd_pend) begin
              state <= S_MCU_RD_ADDR;
            end else if (mcu_wr_pend) begin
              state <= S_MCU_WR_ADDR;
            end
          end
        end
        S_COP_RD_ADDR, S_COP_WR_ADDR, S_MCU_RD_ADDR, S_MCU_WR_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= state_t'({state[7:0], 1'b0});
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_comb begin
    ram.addr  = cop_hit ? cop_addr_q : mcu_addr_q;
    ram.wdata = (state == S_COP_WR_ADDR) ? cop_wdata_q : mcu_wdata_q;
    ram.we_n  = ~((state == S_COP_WR_ADDR) || (state == S_MCU_WR_ADDR));
  end

  always_ff @(posedge CLK2) begin
    if (state == S_MCU_RD_ADDR) begin
      mcu_rdata <= ram_rdata;
    end
    if (state == S_COP_RD_ADDR) begin
      cop_rdata <= ram_rdata;
    end
  end

  a_state_onehot: assert property (
    @(posedge CLK2) disable iff (!arst_n) $onehot(state)
  );

endmodule

// File: rtl/rom_pipeline.sv
`timescale 1ns/1ps

module rom_pipeline
  import snes_pkg::*, mem_pkg::*;
(
  input  logic                  CLK2,
  input  logic                  arst_n,
  input  snes_slot_t            slot,
  input  logic                  is_rom,
  input  mcu_req_t              mcu,
  input  cop_rom_req_t          cop,
  input  logic [ROM_DATA_W-1:0] rom_rdata,
  output rom_bus_t              rom,
  output logic                  mcu_rdy,
  output logic [7:0]            mcu_rdata,
  output logic                  mcu_done,
  output logic                  cop_rdy,
  output logic [ROM_DATA_W-1:0] cop_rdata
);

  // each END state sits one bit above its ADDR state
  typedef enum logic [6:0] {
    S_IDLE        = 7'b0000001,
    S_COP_RD_ADDR = 7'b0000010,
    S_COP_RD_END  = 7'b0000100,
    S_MCU_RD_ADDR = 7'b0001000,
    S_MCU_RD_END  = 7'b0010000,
    S_MCU_WR_ADDR = 7'b0100000,
    S_MCU_WR_END  = 7'b1000000
  } state_t;

  state_t               state;
  logic [DELAY_W-1:0]   delay;
  logic                 mcu_hit;
  logic                 slot_free;
  logic                 mcu_rd_pend;
  logic                 mcu_wr_pend;
  logic                 cop_pend;
  logic [ADDR_W-1:0]    mcu_addr_q;
  logic [7:0]           mcu_wdata_q;
  logic [ADDR_W-1:0]    cop_addr_q;
  logic                 cop_word_q;
  logic                 cop_hit;
  logic                 mcu_rd_hit;
  logic                 mcu_wr_hit;
  logic                 lane_on;
  logic                 word_rd;
  logic                 addr0;

  assign mcu_hit    = (mcu.addr.split.region != RAM_REGION);
  assign slot_free  = slot.cycle_end | ~is_rom | slot.dead;
  assign cop_hit    = (state == S_COP_RD_ADDR);
  assign mcu_rd_hit = (state == S_MCU_RD_ADDR);
  assign mcu_wr_hit = (state == S_MCU_WR_ADDR);
  assign mcu_done   = (state == S_MCU_RD_END);

  // ----------------------------------------------------------------------
  // request capture
  // ----------------------------------------------------------------------

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end else if (mcu.rrq && mcu_hit) begin
      mcu_rd_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (mcu.wrq && mcu_hit) begin
      mcu_wr_pend <= 1'b1;
      mcu_rdy     <= 1'b0;
    end else if (state == S_MCU_RD_END || state == S_MCU_WR_END) begin
      mcu_rd_pend <= 1'b0;
      mcu_wr_pend <= 1'b0;
      mcu_rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      cop_pend <= 1'b0;
      cop_rdy  <= 1'b1;
    end else if (cop.rrq) begin
      cop_pend <= 1'b1;
      cop_rdy  <= 1'b0;
    end else if (cop_hit && delay == '0) begin
      // data is final here, release the coprocessor a cycle early
      cop_rdy <= 1'b1;
    end else if (state == S_COP_RD_END) begin
      cop_pend <= 1'b0;
      cop_rdy  <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if ((mcu.rrq || mcu.wrq) && mcu_hit) begin
      mcu_addr_q  <= mcu.addr.flat;
      mcu_wdata_q <= mcu.wdata;
    end
    if (cop.rrq) begin
      cop_addr_q <= cop.addr;
      cop_word_q <= cop.word;
    end
  end

  // ----------------------------------------------------------------------
  // arbitration FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      state <= S_IDLE;
      delay <= '0;
    end else if (slot.revive) begin
      // console woke up, abort and retry from the pending flags
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          delay <= ROM_CYCLE_LEN;
          if (slot_free) begin
            if (cop_pend || cop.rrq) begin
              state <= S_COP_RD_ADDR;
            end else if (mcu_rd_pend) begin
              state <= S_MCU_RD_ADDR;
            end else if (mcu_wr_pend) begin
              state <= S_MCU_WR_ADDR;
            end
          end
        end
        S_COP_RD_ADDR, S_MCU_RD_ADDR, S_MCU_WR_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= state_t'({state[5:0], 1'b0});
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // byte lanes and read data
  // ----------------------------------------------------------------------

  assign addr0   = cop_hit ? cop_addr_q[0] : mcu_addr_q[0];
  assign lane_on = cop_hit | mcu_rd_hit | mcu_wr_hit;
  assign word_rd = cop_hit & cop_word_q;

  always_comb begin
    rom.addr  = cop_hit ? cop_addr_q[ADDR_W-1:1] : mcu_addr_q[ADDR_W-1:1];
    rom.wdata = addr0 ? {8'h00, mcu_wdata_q} : {mcu_wdata_q, 8'h00};
    rom.we_n  = ~mcu_wr_hit;
    // odd byte on the low lane, even byte on the high lane
    rom.bhe_n = ~(lane_on & (~addr0 | word_rd));
    rom.ble_n = ~(lane_on & (addr0 | word_rd));
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rd_hit) begin
      mcu_rdata <= addr0 ? rom_rdata[7:0] : rom_rdata[15:8];
    end
    // even word address comes back byte swapped
    if (cop_hit) begin
      cop_rdata <= addr0 ? rom_rdata : {rom_rdata[7:0], rom_rdata[15:8]};
    end
  end

  a_state_onehot: assert property (
    @(posedge CLK2) disable iff (!arst_n) $onehot(state)
  );

  a_mcu_single_strobe: assert property (
    @(posedge CLK2) disable iff (!arst_n) !(mcu.rrq && mcu.wrq)
  );

endmodule

// File: rtl/snes_bus_sync.sv
`timescale 1ns/1ps

module snes_bus_sync
  import snes_pkg::*;
#(
  parameter int DEAD_TIMEOUT = DEAD_TIMEOUT_DEFAULT
) (
  input  logic       CLK2,
  input  logic       arst_n,
  input  logic       cpu_clk,
  output snes_slot_t slot
);

  logic [SYNC_DEPTH-1:0] clk_sr;
  logic [5:0]            clk_filt;
  logic                  clk_high;
  logic                  cycle_end_q;
  logic                  dead_q;
  logic [DEAD_CNT_W-1:0] dead_cnt;

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      clk_sr <= '0;
    end else begin
      clk_sr <= {clk_sr[SYNC_DEPTH-2:0], cpu_clk};
    end
  end

  // OR of neighbouring taps bridges a one-sample dropout
  assign clk_filt = clk_sr[SYNC_DEPTH-1 -: 6] | clk_sr[SYNC_DEPTH-2 -: 6];
  assign clk_high = clk_sr[1];

  // three high then three low marks the end of a CPU cycle
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      cycle_end_q <= 1'b0;
    end else begin
      cycle_end_q <= (clk_filt == 6'b111000);
    end
  end

  // ----------------------------------------------------------------------
  // dead console detection
  // ----------------------------------------------------------------------

  // console counts as dead until its clock shows up
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      dead_cnt <= '0;
      dead_q   <= 1'b1;
    end else if (clk_high) begin
      dead_cnt <= '0;
      dead_q   <= 1'b0;
    end else begin
      // saturate once past the limit
      if (dead_cnt <= DEAD_TIMEOUT) begin
        dead_cnt <= dead_cnt + 1'b1;
      end
      if (dead_cnt > DEAD_TIMEOUT) begin
        dead_q <= 1'b1;
      end
    end
  end

  assign slot = '{
    cycle_end: cycle_end_q,
    dead:      dead_q,
    revive:    dead_q & clk_high
  };

endmodule

// File: rtl/snes_pkg.sv
package snes_pkg;

  // ----------------------------------------------------------------------
  // console clock sampling
  // ----------------------------------------------------------------------

  // taps of the CPU clock shift register
  localparam int SYNC_DEPTH = 8;

  // roughly 1 ms of low CPU clock at the core rate
  localparam int DEAD_TIMEOUT_DEFAULT = 96000;

  // wide enough to count past the default timeout
  localparam int DEAD_CNT_W = 18;

  // ----------------------------------------------------------------------
  // bus slot seen by both memory pipelines
  // ----------------------------------------------------------------------

  typedef struct packed {
    // console CPU cycle just finished, address phase is free
    logic cycle_end;
    // no CPU clock for the timeout period
    logic dead;
    // one cycle, console came back while marked dead
    logic revive;
  } snes_slot_t;

endpackage

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter real HALF_PERIOD  = 50.0,
  parameter int  RESET_CYCLES = 10
) (
  output logic CLK2,
  output logic arst_n
);

  initial begin
    CLK2 = 1'b0;
    forever #(HALF_PERIOD) CLK2 = ~CLK2;
  end

  // release reset on a falling edge, away from the DUT's sampling edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK2);
    @(negedge CLK2);
    arst_n = 1'b1;
  end

endmodule

// File: testbench/tb_mem_arbiter.sv
`timescale 1ns/1ps

module tb_mem_arbiter
  import mem_pkg::*;
();

  // ----------------------------------------------------------------------
  // run length
  // ----------------------------------------------------------------------

  // strobe, ADDR and END with the console dead take about a dozen clocks
  localparam int ACCESS_MAX    = 20;
  localparam int ACCESS_COUNT  = 17;
  // warm-up toggling, 30-cycle hold and the live read itself
  localparam int LIVE_TEST_MAX = 150;
  localparam int EST_CYCLES    = 10 + ACCESS_COUNT * ACCESS_MAX + LIVE_TEST_MAX;
  localparam int MAX_CYCLES    = 8 * EST_CYCLES;

  localparam int RDY_MCU     = 0;
  localparam int RDY_COP_ROM = 1;
  localparam int RDY_COP_RAM = 2;

  logic                  CLK2;
  logic                  arst_n;
  logic                  cpu_clk;
  logic                  is_rom;
  logic                  is_saveram;
  mcu_req_t              mcu;
  cop_rom_req_t          cop_rom;
  cop_ram_req_t          cop_ram;
  logic [ROM_DATA_W-1:0] rom_rdata;
  logic [RAM_DATA_W-1:0] ram_rdata;
  rom_bus_t              rom;
  ram_bus_t              ram;
  logic                  mcu_rdy;
  logic [7:0]            mcu_rdata;
  logic                  cop_rom_rdy;
  logic [ROM_DATA_W-1:0] cop_rom_rdata;
  logic                  cop_ram_rdy;
  logic [RAM_DATA_W-1:0] cop_ram_rdata;

  logic [15:0] rom_mem [0:1023];
  logic [7:0]  ram_mem [0:1023];
  int          rom_writes;
  int          cycles;
  logic [31:0] lcg_state;

  tb_clock_gen u_clock_gen (
    .CLK2   (CLK2),
    .arst_n (arst_n)
  );

  mem_arbiter_top #(
    .DEAD_TIMEOUT(20)
  ) u_mem_arbiter_top (
    .CLK2          (CLK2),
    .arst_n        (arst_n),
    .cpu_clk       (cpu_clk),
    .is_rom        (is_rom),
    .is_saveram    (is_saveram),
    .mcu           (mcu),
    .cop_rom       (cop_rom),
    .cop_ram       (cop_ram),
    .rom_rdata     (rom_rdata),
    .ram_rdata     (ram_rdata),
    .rom           (rom),
    .ram           (ram),
    .mcu_rdy       (mcu_rdy),
    .mcu_rdata     (mcu_rdata),
    .cop_rom_rdy   (cop_rom_rdy),
    .cop_rom_rdata (cop_rom_rdata),
    .cop_ram_rdy   (cop_ram_rdy),
    .cop_ram_rdata (cop_ram_rdata)
  );

  // ----------------------------------------------------------------------
  // memory models, 1K deep, filled from the full index
  // ----------------------------------------------------------------------

  function automatic logic [15:0] rom_fill(input int idx);
    rom_fill = 16'((idx * 40503) ^ 16'h3c5a);
  endfunction

  function automatic logic [7:0] ram_fill(input int idx);
    ram_fill = 8'((idx * 37) + (idx >> 8) + 8'h6b);
  endfunction

  initial begin
    for (int i = 0; i < 1024; i++) begin
      rom_mem[i] = rom_fill(i);
      ram_mem[i] = ram_fill(i);
    end
  end

  assign rom_rdata = rom_mem[rom.addr[9:0]];
  assign ram_rdata = ram_mem[ram.addr[9:0]];

  // byte enables pick the lanes of a PSRAM write
  always @(posedge CLK2) begin
    if (rom.we_n === 1'b0) begin
      rom_writes <= rom_writes + 1;
      if (!rom.bhe_n) begin
        rom_mem[rom.addr[9:0]][15:8] <= rom.wdata[15:8];
      end
      if (!rom.ble_n) begin
        rom_mem[rom.addr[9:0]][7:0] <= rom.wdata[7:0];
      end
    end
    if (ram.we_n === 1'b0) begin
      ram_mem[ram.addr[9:0]] <= ram.wdata;
    end
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------

  function automatic logic [7:0] random_byte();
    lcg_state   = lcg_state * 32'd1664525 + 32'd1013904223;
    random_byte = lcg_state[23:16];
  endfunction

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s actual=%h expected=%h",
               $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  function automatic logic ready_of(input int which);
    case (which)
      RDY_MCU:     ready_of = mcu_rdy;
      RDY_COP_ROM: ready_of = cop_rom_rdy;
      default:     ready_of = cop_ram_rdy;
    endcase
  endfunction

  // returns on a falling edge with the ready high
  task automatic wait_ready(input int which);
    while (!ready_of(which)) begin
      @(negedge CLK2);
    end
  endtask

  task automatic mcu_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
    mcu.addr.flat = addr;
    mcu.wdata     = data;
    mcu.wrq       = 1'b1;
    @(negedge CLK2);
    mcu.wrq = 1'b0;
    wait_ready(RDY_MCU);
  endtask

  task automatic mcu_read(input logic [ADDR_W-1:0] addr, output logic [7:0] data);
    mcu.addr.flat = addr;
    mcu.rrq       = 1'b1;
    @(negedge CLK2);
    mcu.rrq = 1'b0;
    wait_ready(RDY_MCU);
    data = mcu_rdata;
  endtask

  task automatic cop_rom_read(input logic [ADDR_W-1:0] addr, output logic [15:0] data);
    cop_rom.addr = addr;
    cop_rom.word = 1'b1;
    cop_rom.rrq  = 1'b1;
    @(negedge CLK2);
    cop_rom.rrq = 1'b0;
    wait_ready(RDY_COP_ROM);
    data = cop_rom_rdata;
  endtask

  task automatic cop_ram_write(input logic [RAM_ADDR_W-1:0] addr, input logic [7:0] data);
    cop_ram.addr  = addr;
    cop_ram.wdata = data;
    cop_ram.wrq   = 1'b1;
    @(negedge CLK2);
    cop_ram.wrq = 1'b0;
    wait_ready(RDY_COP_RAM);
  endtask

  task automatic cop_ram_read(input logic [RAM_ADDR_W-1:0] addr, output logic [7:0] data);
    cop_ram.addr = addr;
    cop_ram.rrq  = 1'b1;
    @(negedge CLK2);
    cop_ram.rrq = 1'b0;
    wait_ready(RDY_COP_RAM);
    data = cop_ram_rdata;
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------

  task automatic reset_defaults();
    check_equal("mcu_rdy", mcu_rdy, 1);
    check_equal("cop_rom_rdy", cop_rom_rdy, 1);
    check_equal("cop_ram_rdy", cop_ram_rdy, 1);
    check_equal("rom.we_n", rom.we_n, 1);
    check_equal("rom.bhe_n", rom.bhe_n, 1);
    check_equal("rom.ble_n", rom.ble_n, 1);
    check_equal("ram.we_n", ram.we_n, 1);
  endtask

  // odd byte lives on the low lane, even byte on the high lane
  task automatic rom_byte_lanes();
    logic [7:0]  d_odd;
    logic [7:0]  d_even;
    logic [7:0]  rd;
    logic [15:0] old_odd;
    logic [15:0] old_even;
    d_odd    = random_byte();
    d_even   = random_byte();
    old_odd  = rom_mem[10'h09a];
    old_even = rom_mem[10'h124];
    mcu_write(24'h000135, d_odd);
    check_equal("rom_mem odd word", rom_mem[10'h09a], {old_odd[15:8], d_odd});
    mcu_write(24'h000248, d_even);
    check_equal("rom_mem even word", rom_mem[10'h124], {d_even, old_even[7:0]});
    mcu_read(24'h000135, rd);
    check_equal("mcu_rdata odd", rd, d_odd);
    mcu_read(24'h000248, rd);
    check_equal("mcu_rdata even", rd, d_even);
  endtask

  task automatic ram_region_access();
    logic [RAM_ADDR_W-1:0] offs [2];
    logic [7:0]            data;
    logic [7:0]            rd;
    int                    writes_before;
    offs[0]       = 19'h00033;
    offs[1]       = 19'h002f1;
    writes_before = rom_writes;
    for (int i = 0; i < 2; i++) begin
      data = random_byte();
      mcu_write({RAM_REGION, offs[i]}, data);
      check_equal("ram_mem", ram_mem[offs[i][9:0]], data);
      mcu_read({RAM_REGION, offs[i]}, rd);
      check_equal("mcu_rdata ram", rd, data);
    end
    check_equal("rom write cycles", rom_writes, writes_before);
  endtask

  task automatic cop_word_reads();
    logic [15:0] word;
    logic [15:0] m;
    logic [7:0]  expected_byte;
    m = rom_mem[10'h188];
    cop_rom_read(24'h000310, word);
    check_equal("cop_rom_rdata even", word, {m[7:0], m[15:8]});
    m = rom_mem[10'h293];
    cop_rom_read(24'h000527, word);
    check_equal("cop_rom_rdata odd", word, m);
    // MCU and coprocessor strobe together, coprocessor wins
    m             = rom_mem[10'h205];
    expected_byte = rom_mem[10'h0f1][7:0];
    mcu.addr.flat = 24'h0001e3;
    mcu.rrq       = 1'b1;
    cop_rom.addr  = 24'h00040a;
    cop_rom.rrq   = 1'b1;
    @(negedge CLK2);
    mcu.rrq     = 1'b0;
    cop_rom.rrq = 1'b0;
    wait_ready(RDY_COP_ROM);
    check_equal("mcu_rdy at cop done", mcu_rdy, 0);
    check_equal("cop_rom_rdata shared", cop_rom_rdata, {m[7:0], m[15:8]});
    wait_ready(RDY_MCU);
    check_equal("mcu_rdata shared", mcu_rdata, expected_byte);
  endtask

  task automatic cop_ram_roundtrip();
    logic [RAM_ADDR_W-1:0] offs [2];
    logic [7:0]            data [2];
    logic [7:0]            rd;
    offs[0] = 19'h00100;
    offs[1] = 19'h003fe;
    for (int i = 0; i < 2; i++) begin
      data[i] = random_byte();
      cop_ram_write(offs[i], data[i]);
    end
    for (int i = 0; i < 2; i++) begin
      cop_ram_read(offs[i], rd);
      check_equal("cop_ram_rdata", rd, data[i]);
    end
  endtask

  // console alive, the ROM slot only frees after a CPU cycle end
  task automatic live_console_read();
    logic [7:0] expected_byte;
    int         n;
    is_rom = 1'b1;
    for (int i = 0; i < 48; i++) begin
      cpu_clk = ((i % 12) < 6);
      @(negedge CLK2);
    end
    cpu_clk = 1'b1;
    repeat (3) @(negedge CLK2);
    expected_byte = rom_mem[10'h0a3][15:8];
    mcu.addr.flat = 24'h000146;
    mcu.rrq       = 1'b1;
    @(negedge CLK2);
    mcu.rrq = 1'b0;
    for (int i = 0; i < 30; i++) begin
      check_equal("mcu_rdy while cpu clock high", mcu_rdy, 0);
      @(negedge CLK2);
    end
    cpu_clk = 1'b0;
    n       = 0;
    while (!mcu_rdy) begin
      @(negedge CLK2);
      n++;
      cpu_clk = ((n % 12) >= 6);
    end
    // four low samples to see the cycle end, then ADDR and END
    if (n < 4 + int'(ROM_CYCLE_LEN) + 2) begin
      $display("live console read finished %0d cycles after the clock fell, too early", n);
      $display("Simulation failed");
      $fatal(1);
    end
    check_equal("mcu_rdata live", mcu_rdata, expected_byte);
  endtask

  // ----------------------------------------------------------------------
  // watchdog and main sequence
  // ----------------------------------------------------------------------

  always @(posedge CLK2) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  initial begin
    cycles     = 0;
    rom_writes = 0;
    lcg_state  = 32'hd197_7649;
    cpu_clk    = 1'b0;
    is_rom     = 1'b0;
    is_saveram = 1'b0;
    mcu        = '0;
    cop_rom    = '0;
    cop_ram    = '0;
    @(posedge arst_n);
    @(negedge CLK2);
    reset_defaults();
    rom_byte_lanes();
    ram_region_access();
    cop_word_reads();
    cop_ram_roundtrip();
    live_console_read();
    $display("Simulation passed");
    $finish;
  end

endmodule
